/* design/aes_defs.svh */
// AES-128 decryptor widths and round count
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

`define AES_BLOCK_W    128
`define AES_WORD_W     32
`define AES_BYTE_W     8
`define AES_NUM_ROUNDS 10
`define AES_ROUND_W    4

`endif

/* design/aes_ctrl_pkg.sv */
// AES decryptor control encodings for the FSM, key schedule, counter and datapath
package aes_ctrl_pkg;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXPAND,
        S_DECRYPT,
        S_DONE
    } fsm_state_t;

    // OP_LOAD takes the ciphertext into the state register
    typedef enum logic [1:0] {
        OP_ADD_KEY,
        OP_FULL_ROUND,
        OP_FINAL_ROUND,
        OP_LOAD
    } round_op_t;

    typedef enum logic [1:0] {
        KEY_HOLD,
        KEY_LOAD,
        KEY_FWD,
        KEY_BWD
    } key_op_t;

    typedef enum logic [2:0] {
        CTR_HOLD,
        CTR_UP_FROM_0,
        CTR_DOWN_FROM_10,
        CTR_UP,
        CTR_DOWN
    } ctr_mode_t;

endpackage

/* design/aes_data_pkg.sv */
// AES data types, GF(2^8) arithmetic, InvShiftRows, InvMixColumns and round constants
`include "aes_defs.svh"

package aes_data_pkg;

    typedef logic [`AES_BYTE_W-1:0]  byte_t;
    typedef logic [`AES_WORD_W-1:0]  word_t;
    typedef logic [`AES_BLOCK_W-1:0] block_t;
    typedef logic [`AES_ROUND_W-1:0] round_t;

    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Multiply by a 4-bit constant, bit k selects b * 2^k
    function automatic byte_t gf_mul(byte_t b, logic [3:0] k);
        byte_t x2;
        byte_t x4;
        byte_t x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return (k[3] ? x8 : 8'h00) ^ (k[2] ? x4 : 8'h00) ^
               (k[1] ? x2 : 8'h00) ^ (k[0] ? b : 8'h00);
    endfunction

    // Byte 0 is the most significant, column-major
    function automatic block_t inv_shift_rows(block_t s);
        block_t r;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                r[127-8*(4*c+row) -: 8] = s[127-8*(4*((c-row+4)%4)+row) -: 8];
            end
        end
        return r;
    endfunction

    function automatic block_t inv_mix_columns(block_t s);
        byte_t a0, a1, a2, a3;
        block_t r;
        for (int c = 0; c < 4; c++) begin
            a0 = s[127-32*c -: 8];
            a1 = s[119-32*c -: 8];
            a2 = s[111-32*c -: 8];
            a3 = s[103-32*c -: 8];
            r[127-32*c -: 8] = gf_mul(a0, 4'he) ^ gf_mul(a1, 4'hb) ^
                               gf_mul(a2, 4'hd) ^ gf_mul(a3, 4'h9);
            r[119-32*c -: 8] = gf_mul(a0, 4'h9) ^ gf_mul(a1, 4'he) ^
                               gf_mul(a2, 4'hb) ^ gf_mul(a3, 4'hd);
            r[111-32*c -: 8] = gf_mul(a0, 4'hd) ^ gf_mul(a1, 4'h9) ^
                               gf_mul(a2, 4'he) ^ gf_mul(a3, 4'hb);
            r[103-32*c -: 8] = gf_mul(a0, 4'hb) ^ gf_mul(a1, 4'hd) ^
                               gf_mul(a2, 4'h9) ^ gf_mul(a3, 4'he);
        end
        return r;
    endfunction

    function automatic word_t rcon_of(round_t idx);
        case (idx)
            4'd0:    return 32'h0100_0000;
            4'd1:    return 32'h0200_0000;
            4'd2:    return 32'h0400_0000;
            4'd3:    return 32'h0800_0000;
            4'd4:    return 32'h1000_0000;
            4'd5:    return 32'h2000_0000;
            4'd6:    return 32'h4000_0000;
            4'd7:    return 32'h8000_0000;
            4'd8:    return 32'h1b00_0000;
            4'd9:    return 32'h3600_0000;
            default: return 32'h0000_0000;
        endcase
    endfunction

endpackage

/* design/aes_sbox.sv */
// Forward AES S-box, combinational byte substitution for the key schedule
`timescale 1ns/1ps

module aes_sbox (
    input  aes_data_pkg::byte_t in,
    output aes_data_pkg::byte_t out
);
    import aes_data_pkg::*;

    // Indexed by input byte, row of 8 per line
    localparam byte_t SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    assign out = SBOX[in];

endmodule

/* design/aes_inv_sbox.sv */
// Inverse AES S-box, combinational byte substitution for InvSubBytes
`timescale 1ns/1ps

module aes_inv_sbox (
    input  aes_data_pkg::byte_t in,
    output aes_data_pkg::byte_t out
);
    import aes_data_pkg::*;

    localparam byte_t INV_SBOX [0:255] = '{
        8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
        8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
        8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
        8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
        8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
        8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
        8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
        8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
        8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
        8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
        8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
        8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
        8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
        8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
        8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
        8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
        8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
        8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
        8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
        8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
        8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
        8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
        8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
        8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
        8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
        8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
        8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
        8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
        8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
        8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
        8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
        8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
    };

    assign out = INV_SBOX[in];

endmodule

/* design/aes_key_sched.sv */
// AES-128 round key register, stepped forward or backward one round per cycle
`timescale 1ns/1ps

module aes_key_sched (
    input  logic                    clk,
    input  logic                    rst_n,
    input  aes_ctrl_pkg::key_op_t   key_op,
    input  aes_data_pkg::block_t    key,
    input  aes_data_pkg::round_t    round,
    output aes_data_pkg::block_t    round_key
);
    import aes_ctrl_pkg::*;
    import aes_data_pkg::*;

    block_t rk_q;
    word_t  w0, w1, w2, w3;
    word_t  prev_w3;
    word_t  rot_src;
    word_t  rot_word;
    word_t  sub_word;
    word_t  g_word;
    round_t rcon_idx;
    block_t fwd_key;
    block_t bwd_key;

    assign {w0, w1, w2, w3} = rk_q;

    // Last word of the previous round key, needed to undo the g() term
    assign prev_w3  = w3 ^ w2;
    assign rot_src  = (key_op == KEY_BWD) ? prev_w3 : w3;
    assign rot_word = {rot_src[23:0], rot_src[31:24]};
    assign rcon_idx = (key_op == KEY_BWD) ? round - round_t'(1) : round;

    for (genvar i = 0; i < 4; i++) begin : g_sub_word
        aes_sbox u_sbox (
            .in  (rot_word[8*i +: 8]),
            .out (sub_word[8*i +: 8])
        );
    end

    assign g_word = sub_word ^ rcon_of(rcon_idx);

    assign fwd_key[127:96] = w0 ^ g_word;
    assign fwd_key[95:64]  = w1 ^ fwd_key[127:96];
    assign fwd_key[63:32]  = w2 ^ fwd_key[95:64];
    assign fwd_key[31:0]   = w3 ^ fwd_key[63:32];

    assign bwd_key = {w0 ^ g_word, w1 ^ w0, w2 ^ w1, prev_w3};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rk_q <= '0;
        end else begin
            case (key_op)
                KEY_LOAD: rk_q <= key;
                KEY_FWD:  rk_q <= fwd_key;
                KEY_BWD:  rk_q <= bwd_key;
                default:  rk_q <= rk_q;
            endcase
        end
    end

    assign round_key = rk_q;

endmodule

/* design/aes_round_dp.sv */
// AES inverse cipher datapath, state register plus one round per cycle
`timescale 1ns/1ps

module aes_round_dp (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    state_load,
    input  aes_ctrl_pkg::round_op_t round_op,
    input  aes_data_pkg::block_t    ciphertext,
    input  aes_data_pkg::block_t    round_key,
    output aes_data_pkg::block_t    plaintext
);
    import aes_ctrl_pkg::*;
    import aes_data_pkg::*;

    block_t state_q;
    block_t shifted;
    block_t subbed;
    block_t keyed;
    block_t state_d;

    // ============================================================
    // Round function
    // ============================================================
    assign shifted = inv_shift_rows(state_q);

    // InvSubBytes is bytewise, so byte order is irrelevant here
    for (genvar i = 0; i < 16; i++) begin : g_inv_sub
        aes_inv_sbox u_inv_sbox (
            .in  (shifted[8*i +: 8]),
            .out (subbed[8*i +: 8])
        );
    end

    assign keyed = subbed ^ round_key;

    always_comb begin
        case (round_op)
            OP_LOAD:       state_d = ciphertext;
            OP_ADD_KEY:    state_d = state_q ^ round_key;
            OP_FULL_ROUND: state_d = inv_mix_columns(keyed);
            default:       state_d = keyed;
        endcase
    end

    // ============================================================
    // State register
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (state_load) begin
            state_q <= state_d;
        end
    end

    assign plaintext = state_q;

endmodule

/* design/aes_round_ctr.sv */
// Round index counter, loads 0 or 10 and counts up or down with terminal flag
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_round_ctr (
    input  logic                    clk,
    input  logic                    rst_n,
    input  aes_ctrl_pkg::ctr_mode_t ctr_mode,
    output aes_data_pkg::round_t    round,
    output logic                    round_last
);
    import aes_ctrl_pkg::*;
    import aes_data_pkg::*;

    round_t round_q;
    logic   count_down;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            round_q    <= '0;
            count_down <= 1'b0;
        end else begin
            case (ctr_mode)
                CTR_UP_FROM_0: begin
                    round_q    <= '0;
                    count_down <= 1'b0;
                end
                CTR_DOWN_FROM_10: begin
                    round_q    <= round_t'(`AES_NUM_ROUNDS);
                    count_down <= 1'b1;
                end
                CTR_UP:   round_q <= round_q + round_t'(1);
                CTR_DOWN: round_q <= round_q - round_t'(1);
                default:  round_q <= round_q;
            endcase
        end
    end

    assign round = round_q;

    // Key expansion ends on step 9, decryption on round 0
    assign round_last = count_down ? (round_q == '0)
                                   : (round_q == round_t'(`AES_NUM_ROUNDS - 1));

endmodule

/* design/aes_ctrl_fsm.sv */
// Decryptor sequencing FSM with input and output valid/ready handshakes
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_ctrl_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic                    out_valid,
    input  logic                    out_ready,
    input  aes_data_pkg::round_t    round,
    input  logic                    round_last,
    output aes_ctrl_pkg::key_op_t   key_op,
    output aes_ctrl_pkg::ctr_mode_t ctr_mode,
    output aes_ctrl_pkg::round_op_t round_op,
    output logic                    state_load
);
    import aes_ctrl_pkg::*;

    fsm_state_t state_q;
    fsm_state_t state_d;
    round_op_t  dec_op;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Round 10 is the initial AddRoundKey, round 0 skips InvMixColumns
    always_comb begin
        if (round == `AES_ROUND_W'(`AES_NUM_ROUNDS)) begin
            dec_op = OP_ADD_KEY;
        end else if (round == '0) begin
            dec_op = OP_FINAL_ROUND;
        end else begin
            dec_op = OP_FULL_ROUND;
        end
    end

    assign in_ready  = (state_q == S_IDLE);
    assign out_valid = (state_q == S_DONE);

    always_comb begin
        state_d    = state_q;
        key_op     = KEY_HOLD;
        ctr_mode   = CTR_HOLD;
        round_op   = OP_LOAD;
        state_load = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (in_valid) begin
                    key_op     = KEY_LOAD;
                    ctr_mode   = CTR_UP_FROM_0;
                    state_load = 1'b1;
                    state_d    = S_EXPAND;
                end
            end
            S_EXPAND: begin
                key_op   = KEY_FWD;
                ctr_mode = round_last ? CTR_DOWN_FROM_10 : CTR_UP;
                if (round_last) begin
                    state_d = S_DECRYPT;
                end
            end
            S_DECRYPT: begin
                round_op   = dec_op;
                state_load = 1'b1;
                key_op     = round_last ? KEY_HOLD : KEY_BWD;
                ctr_mode   = round_last ? CTR_HOLD : CTR_DOWN;
                if (round_last) begin
                    state_d = S_DONE;
                end
            end
            default: begin
                if (out_ready) begin
                    state_d = S_IDLE;
                end
            end
        endcase
    end

endmodule

/* design/aes_decrypt_top.sv */
// Iterative AES-128 decryptor top level with valid/ready handshakes
`timescale 1ns/1ps

module aes_decrypt_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  aes_data_pkg::block_t ciphertext,
    input  aes_data_pkg::block_t key,
    output logic                 out_valid,
    input  logic                 out_ready,
    output aes_data_pkg::block_t plaintext
);
    import aes_ctrl_pkg::*;
    import aes_data_pkg::*;

    key_op_t   key_op;
    ctr_mode_t ctr_mode;
    round_op_t round_op;
    logic      state_load;
    round_t    round;
    logic      round_last;
    block_t    round_key;

    aes_ctrl_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .round      (round),
        .round_last (round_last),
        .key_op     (key_op),
        .ctr_mode   (ctr_mode),
        .round_op   (round_op),
        .state_load (state_load)
    );

    aes_round_ctr u_ctr (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctr_mode   (ctr_mode),
        .round      (round),
        .round_last (round_last)
    );

    aes_key_sched u_key (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_op    (key_op),
        .key       (key),
        .round     (round),
        .round_key (round_key)
    );

    aes_round_dp u_dp (
        .clk        (clk),
        .rst_n      (rst_n),
        .state_load (state_load),
        .round_op   (round_op),
        .ciphertext (ciphertext),
        .round_key  (round_key),
        .plaintext  (plaintext)
    );

endmodule

/* dv/aes_decrypt_properties.sv */
// Handshake and latency assertions for the AES-128 decryptor
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_decrypt_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input aes_data_pkg::block_t plaintext
);

    localparam int LATENCY = 2 * `AES_NUM_ROUNDS + 1;

    a_ready_valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high in the same cycle");

    a_output_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(plaintext)))
        else $error("output changed while stalled by out_ready");

    // Result registered on edge 21, so first sampled high one edge later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && in_ready) |=> (!out_valid [*LATENCY]) ##1 out_valid)
        else $error("out_valid did not rise exactly %0d cycles after accept", LATENCY);

endmodule

bind aes_decrypt_top aes_decrypt_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .plaintext (plaintext)
);

/* dv/aes_decrypt_tb.sv */
// Testbench for the iterative AES-128 decryptor, known-answer vectors with back-pressure
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_decrypt_tb;

    localparam int LATENCY     = 2 * `AES_NUM_ROUNDS + 1;
    localparam int NUM_VECTORS = 6;
    localparam int WAIT_LIMIT  = 100;

    typedef logic [`AES_BLOCK_W-1:0] blk_t;

    typedef struct packed {
        blk_t       key;
        blk_t       ct;
        blk_t       pt;
        logic [7:0] delay;
    } vector_t;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    blk_t    ciphertext;
    blk_t    key;
    logic    out_valid;
    logic    out_ready;
    blk_t    plaintext;

    vector_t vectors [NUM_VECTORS];
    int      stall_len [NUM_VECTORS];
    integer  seed;

    aes_decrypt_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .ciphertext (ciphertext),
        .key        (key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .plaintext  (plaintext)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input blk_t got, input blk_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at t=%0t, the %s never completed", $time, what);
        $display("Some tests failed");
        $fatal(1, "stopping on timeout");
    endtask

    // ============================================================
    // Known-answer vectors, delay 0 means back-to-back
    // ============================================================
    task automatic load_vectors();
        vectors[0] = '{128'h000102030405060708090a0b0c0d0e0f,
                       128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                       128'h00112233445566778899aabbccddeeff, 8'd0};
        vectors[1] = '{128'h2b7e151628aed2a6abf7158809cf4f3c,
                       128'h3925841d02dc09fbdc118597196a0b32,
                       128'h3243f6a8885a308d313198a2e0370734, 8'd0};
        vectors[2] = '{128'h0,
                       128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
                       128'h0, 8'd3};
        vectors[3] = vectors[1];
        vectors[4] = vectors[0];
        vectors[4].delay = 8'd5;
        vectors[5] = vectors[2];
        vectors[5].delay = 8'd0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (vectors[i].delay == 0) begin
                stall_len[i] = 0;
            end else begin
                stall_len[i] = vectors[i].delay + ($unsigned($random(seed)) % 8);
            end
        end
    endtask

    task automatic present_input(input int idx);
        in_valid   <= 1'b1;
        key        <= vectors[idx].key;
        ciphertext <= vectors[idx].ct;
        out_ready  <= (stall_len[idx] == 0);
    endtask

    task automatic run_vector(input int idx);
        int   waited;
        int   latency;
        blk_t held;
        waited = 0;
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) report_timeout("input handshake");
            @(negedge clk);
        end
        // Accept edge, then scramble inputs so only the registers carry the block
        @(posedge clk);
        in_valid   <= 1'b0;
        key        <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        ciphertext <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        latency = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_value("in_ready", in_ready, 1'b0);
            latency++;
            if (latency > WAIT_LIMIT) report_timeout("decryption (out_valid)");
            @(negedge clk);
        end
        check_value("latency", latency, LATENCY);
        check_value("plaintext", plaintext, vectors[idx].pt);
        check_value("in_ready", in_ready, 1'b0);
        held = plaintext;
        for (int s = 0; s < stall_len[idx]; s++) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 1'b1);
            check_value("in_ready", in_ready, 1'b0);
            check_value("plaintext", plaintext, held);
        end
        if (stall_len[idx] != 0) begin
            @(posedge clk);
            out_ready <= 1'b1;
            @(negedge clk);
            check_value("out_valid", out_valid, 1'b1);
            check_value("plaintext", plaintext, held);
        end
        // Output transfer edge, next block offered on the same edge
        @(posedge clk);
        if (idx + 1 < NUM_VECTORS) begin
            present_input(idx + 1);
        end else begin
            in_valid  <= 1'b0;
            out_ready <= 1'b0;
        end
        @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
    endtask

    initial begin
        seed       = 40;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        key        = '0;
        ciphertext = '0;
        load_vectors();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("in_ready", in_ready, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
        @(posedge clk);
        present_input(0);
        @(negedge clk);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/aes_ctrl_pkg.sv
design/aes_data_pkg.sv
design/aes_sbox.sv
design/aes_inv_sbox.sv
design/aes_key_sched.sv
design/aes_round_dp.sv
design/aes_round_ctr.sv
design/aes_ctrl_fsm.sv
design/aes_decrypt_top.sv
dv/aes_decrypt_properties.sv
dv/aes_decrypt_tb.sv

/* Bender.yml */
package:
  name: aes_decrypt

export_include_dirs:
  - design

sources:
  - files:
      - design/aes_ctrl_pkg.sv
      - design/aes_data_pkg.sv
      - design/aes_sbox.sv
      - design/aes_inv_sbox.sv
      - design/aes_key_sched.sv
      - design/aes_round_dp.sv
      - design/aes_round_ctr.sv
      - design/aes_ctrl_fsm.sv
      - design/aes_decrypt_top.sv
  - target: simulation
    files:
      - dv/aes_decrypt_properties.sv
      - dv/aes_decrypt_tb.sv
